/* build.f */
rtl/seq_pkg.sv
rtl/redirect_pkg.sv
rtl/seq_age.sv
rtl/seq_alloc.sv
rtl/redirect_select.sv
rtl/seq_track_top.sv
testbench/seq_track_chk.sv
testbench/seq_track_tb.sv

/* rtl/redirect_pkg.sv */
//----------------------------------------
// redirect payload definitions
// target is a plain pc, no alignment checks
//----------------------------------------
`default_nettype none

package redirect_pkg;

  localparam int pc_bits = 32;

  // why the pipe asked for a redirect
  typedef enum logic [1:0] {
    cause_branch,
    cause_jump,
    cause_exception
  } redirect_cause_t;

endpackage

`default_nettype wire

/* rtl/redirect_select.sv */
//----------------------------------------
// picks the older of two pipe redirects
// stale requests outside the window are dropped
// winner is registered and held one cycle
//----------------------------------------
`default_nettype none

module redirect_select
  import seq_pkg::*;
  import redirect_pkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  logic               exe0_redirect_val,
  input  logic               exe1_redirect_val,
  input  seq_num_t           exe0_seq_num,
  input  seq_num_t           exe1_seq_num,
  input  logic [pc_bits-1:0] exe0_target,
  input  logic [pc_bits-1:0] exe1_target,
  input  redirect_cause_t    exe0_cause,
  input  redirect_cause_t    exe1_cause,
  input  seq_num_t           oldest_seq_num,
  input  seq_count_t         in_flight,
  output logic               redirect_val,
  output seq_num_t           redirect_seq_num,
  output logic [pc_bits-1:0] redirect_target,
  output redirect_cause_t    redirect_cause
);

  seq_num_t age0;
  seq_num_t age1;
  logic     qual0;
  logic     qual1;
  logic     pick1;
  logic     any_qual;

  //----------------------------------------
  // screening
  //----------------------------------------

  // age relative to the oldest in-flight entry
  assign age0 = seq_age_of(exe0_seq_num, oldest_seq_num);
  assign age1 = seq_age_of(exe1_seq_num, oldest_seq_num);

  // only live entries may redirect
  // in_flight here is the pre-rewind value
  assign qual0 = exe0_redirect_val && (age0 < in_flight);
  assign qual1 = exe1_redirect_val && (age1 < in_flight);

  //----------------------------------------
  // arbitration
  //----------------------------------------

  // pipe 1 only when strictly older
  // equal ages go to pipe 0
  assign pick1    = qual1 && (!qual0 || (age1 < age0));
  assign any_qual = qual0 || qual1;

  //----------------------------------------
  // output register
  //----------------------------------------

  // valid for exactly one cycle per sample
  always_ff @(posedge clk) begin
    if (reset) begin
      redirect_val <= 1'b0;
    end else begin
      redirect_val <= any_qual;
    end
  end

  // payload only loaded on a winner
  always_ff @(posedge clk) begin
    if (any_qual) begin
      if (pick1) begin
        redirect_seq_num <= exe1_seq_num;
        redirect_target  <= exe1_target;
        redirect_cause   <= exe1_cause;
      end else begin
        redirect_seq_num <= exe0_seq_num;
        redirect_target  <= exe0_target;
        redirect_cause   <= exe0_cause;
      end
    end
  end

  // Payload holds its last value while redirect_val is low,
  // consumers must look at redirect_val first.

endmodule

`default_nettype wire

/* rtl/seq_age.sv */
//----------------------------------------
// oldest in-flight pointer, moved by commit
// an illegal commit still moves the pointer
// error flag is sticky until reset
//----------------------------------------
`default_nettype none

module seq_age
  import seq_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       commit_val,
  input  seq_num_t   commit_seq_num,
  input  seq_count_t in_flight,
  output seq_num_t   oldest_seq_num,
  output logic       commit_order_error
);

  logic commit_bad;

  // commit must hit the oldest entry
  // and something has to be in flight
  assign commit_bad = commit_val &&
                      ((commit_seq_num != oldest_seq_num) || (in_flight == '0));

  //----------------------------------------
  // oldest pointer
  //----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      oldest_seq_num <= '0;
    end else if (commit_val) begin
      // step past the committed entry
      oldest_seq_num <= commit_seq_num + seq_num_t'(1);
    end
  end

  // sticky order error
  always_ff @(posedge clk) begin
    if (reset) begin
      commit_order_error <= 1'b0;
    end else if (commit_bad) begin
      commit_order_error <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* rtl/seq_alloc.sv */
//----------------------------------------
// next-number allocator with redirect rewind
// no back-pressure, callers must honor alloc_full
//----------------------------------------
`default_nettype none

module seq_alloc
  import seq_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       alloc_req,
  input  logic       redirect_val,
  input  seq_num_t   oldest_seq_num,
  input  seq_num_t   redirect_seq_num,
  output seq_num_t   alloc_seq_num,
  output seq_count_t in_flight,
  output logic       alloc_full
);

  // next number to hand out
  seq_num_t next_seq_num;
  logic     alloc_fire;

  //----------------------------------------
  // window status
  //----------------------------------------

  // wrapping distance from oldest to next
  assign in_flight  = seq_count_t'(next_seq_num - oldest_seq_num);
  assign alloc_full = (in_flight == seq_count_t'(seq_window));

  // next number is always visible
  assign alloc_seq_num = next_seq_num;

  // dispatch blocked when full or rewinding
  assign alloc_fire = alloc_req && !alloc_full && !redirect_val;

  //----------------------------------------
  // next pointer
  //----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      next_seq_num <= '0;
    end else if (redirect_val) begin
      // squash everything younger than the redirect
      next_seq_num <= redirect_seq_num + seq_num_t'(1);
    end else if (alloc_fire) begin
      next_seq_num <= next_seq_num + seq_num_t'(1);
    end
  end

  // rewind wins over dispatch in the same cycle
  // in_flight never wraps past seq_window since
  // alloc_fire is gated by alloc_full

endmodule

`default_nettype wire

/* rtl/seq_pkg.sv */
//----------------------------------------
// sequence numbers wrap at 2**seq_num_bits
// at most seq_window may be in flight, so ages are unambiguous
//----------------------------------------
`default_nettype none

package seq_pkg;

  //----------------------------------------
  // widths and window
  //----------------------------------------

  localparam int seq_num_bits = 5;

  // half the wrap length keeps age unambiguous
  localparam int seq_window = 2 ** (seq_num_bits - 1);

  typedef logic [seq_num_bits-1:0] seq_num_t;

  // in-flight count, 0 up to seq_window
  typedef logic [seq_num_bits-1:0] seq_count_t;

  //----------------------------------------
  // age helper
  //----------------------------------------

  // distance from oldest, smaller means older
  function automatic seq_num_t seq_age_of(input seq_num_t seq_num, input seq_num_t oldest);
    return seq_num - oldest;
  endfunction

endpackage

`default_nettype wire

/* rtl/seq_track_top.sv */
//----------------------------------------
// sequence tracking top, two redirect pipes
// all ports are plain strobes, no handshake
//----------------------------------------
`default_nettype none

module seq_track_top
  import seq_pkg::*;
  import redirect_pkg::*;
(
  input  logic               clk,
  input  logic               reset,
  // dispatch and commit
  input  logic               alloc_req,
  input  logic               commit_val,
  input  seq_num_t           commit_seq_num,
  // execute pipe redirects
  input  logic               exe0_redirect_val,
  input  seq_num_t           exe0_seq_num,
  input  logic [pc_bits-1:0] exe0_target,
  input  redirect_cause_t    exe0_cause,
  input  logic               exe1_redirect_val,
  input  seq_num_t           exe1_seq_num,
  input  logic [pc_bits-1:0] exe1_target,
  input  redirect_cause_t    exe1_cause,
  // status
  output seq_num_t           alloc_seq_num,
  output logic               alloc_full,
  output seq_num_t           oldest_seq_num,
  output seq_count_t         in_flight,
  output logic               redirect_val,
  output seq_num_t           redirect_seq_num,
  output logic [pc_bits-1:0] redirect_target,
  output redirect_cause_t    redirect_cause,
  output logic               commit_order_error
);

  //----------------------------------------
  // oldest tracker
  //----------------------------------------

  seq_age age0 (
    .clk                (clk),
    .reset              (reset),
    .commit_val         (commit_val),
    .commit_seq_num     (commit_seq_num),
    .in_flight          (in_flight),
    .oldest_seq_num     (oldest_seq_num),
    .commit_order_error (commit_order_error)
  );

  // allocator, rewound by the selected redirect
  seq_alloc alloc0 (
    .clk              (clk),
    .reset            (reset),
    .alloc_req        (alloc_req),
    .redirect_val     (redirect_val),
    .oldest_seq_num   (oldest_seq_num),
    .redirect_seq_num (redirect_seq_num),
    .alloc_seq_num    (alloc_seq_num),
    .in_flight        (in_flight),
    .alloc_full       (alloc_full)
  );

  //----------------------------------------
  // redirect arbitration
  //----------------------------------------

  redirect_select sel0 (
    .clk               (clk),
    .reset             (reset),
    .exe0_redirect_val (exe0_redirect_val),
    .exe1_redirect_val (exe1_redirect_val),
    .exe0_seq_num      (exe0_seq_num),
    .exe1_seq_num      (exe1_seq_num),
    .exe0_target       (exe0_target),
    .exe1_target       (exe1_target),
    .exe0_cause        (exe0_cause),
    .exe1_cause        (exe1_cause),
    .oldest_seq_num    (oldest_seq_num),
    .in_flight         (in_flight),
    .redirect_val      (redirect_val),
    .redirect_seq_num  (redirect_seq_num),
    .redirect_target   (redirect_target),
    .redirect_cause    (redirect_cause)
  );

endmodule

`default_nettype wire

/* testbench/seq_track_chk.sv */
//----------------------------------------
// protocol assertions bound into seq_track_top
// all checks are held off during reset
//----------------------------------------
`default_nettype none

module seq_track_chk
  import seq_pkg::*;
(
  input logic       clk,
  input logic       reset,
  input logic       exe0_redirect_val,
  input logic       exe1_redirect_val,
  input logic       redirect_val,
  input seq_num_t   alloc_seq_num,
  input logic       alloc_full,
  input seq_count_t in_flight,
  input logic       commit_order_error
);

  timeunit 1ns;
  timeprecision 100ps;

  logic req_any;

  // failed assertions so far, read by the testbench
  int assert_fails = 0;

  assign req_any = exe0_redirect_val || exe1_redirect_val;

  // back to back redirects need a request behind each one
  redirect_single: assert property (@(posedge clk) disable iff (reset)
    redirect_val && $past(redirect_val) |-> $past(req_any, 1) && $past(req_any, 2))
    else begin
      $error("redirect_val held without a request");
      assert_fails++;
    end

  // window never grows past its limit
  window_limit: assert property (@(posedge clk) disable iff (reset)
    in_flight <= seq_count_t'(seq_window))
    else begin
      $error("in_flight above seq_window");
      assert_fails++;
    end

  // full blocks dispatch, only a rewind may move next
  full_holds: assert property (@(posedge clk) disable iff (reset)
    alloc_full && !redirect_val |=> $stable(alloc_seq_num))
    else begin
      $error("alloc_seq_num moved while full");
      assert_fails++;
    end

  // sticky flag
  error_sticky: assert property (@(posedge clk) disable iff (reset)
    $fell(commit_order_error) |-> $past(reset))
    else begin
      $error("commit_order_error cleared without reset");
      assert_fails++;
    end

endmodule

bind seq_track_top seq_track_chk chk0 (
  .clk                (clk),
  .reset              (reset),
  .exe0_redirect_val  (exe0_redirect_val),
  .exe1_redirect_val  (exe1_redirect_val),
  .redirect_val       (redirect_val),
  .alloc_seq_num      (alloc_seq_num),
  .alloc_full         (alloc_full),
  .in_flight          (in_flight),
  .commit_order_error (commit_order_error)
);

`default_nettype wire

/* testbench/seq_track_tb.sv */
//----------------------------------------
// directed and random checks of seq_track_top
// reference model mirrors oldest, next and redirect
// stimulus only issues legal commits until the final case
//----------------------------------------
`default_nettype none

module seq_track_tb
  import seq_pkg::*;
  import redirect_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int wrap = 2 ** seq_num_bits;
  localparam int wait_limit = 40;
  localparam logic [31:0] seed = 32'h122ba2dd;

  logic clk;
  logic reset;
  logic alloc_req;
  logic commit_val;
  seq_num_t commit_seq_num;
  logic exe0_redirect_val;
  logic exe1_redirect_val;
  seq_num_t exe0_seq_num;
  seq_num_t exe1_seq_num;
  logic [pc_bits-1:0] exe0_target;
  logic [pc_bits-1:0] exe1_target;
  redirect_cause_t exe0_cause;
  redirect_cause_t exe1_cause;
  seq_num_t alloc_seq_num;
  logic alloc_full;
  seq_num_t oldest_seq_num;
  seq_count_t in_flight;
  logic redirect_val;
  seq_num_t redirect_seq_num;
  logic [pc_bits-1:0] redirect_target;
  redirect_cause_t redirect_cause;
  logic commit_order_error;

  // reference state
  int ref_oldest;
  int ref_next;
  logic ref_err;
  logic exp_rv;
  seq_num_t exp_rseq;
  logic [pc_bits-1:0] exp_rtarget;
  redirect_cause_t exp_rcause;

  int errors;
  int test_start;
  int tests_done;
  logic [31:0] rng;

  seq_track_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //----------------------------------------
  // reference functions
  //----------------------------------------

  function automatic int ref_age(input int s, input int oldest);
    return (s - oldest + wrap) % wrap;
  endfunction

  function automatic int ref_count();
    return (ref_next - ref_oldest + wrap) % wrap;
  endfunction

  // live requests only, older wins, tie to pipe 0
  function automatic void ref_pick(input logic v0, input int s0, input logic v1, input int s1,
                                   input int oldest, input int cnt, output logic val,
                                   output logic p1);
    logic q0;
    logic q1;
    q0 = v0 && (ref_age(s0, oldest) < cnt);
    q1 = v1 && (ref_age(s1, oldest) < cnt);
    val = q0 || q1;
    p1 = q1 && (!q0 || (ref_age(s1, oldest) < ref_age(s0, oldest)));
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // model steps on the same edge as the DUT
  always @(posedge clk) begin
    int cnt;
    logic pv;
    logic p1;
    if (reset) begin
      ref_oldest = 0;
      ref_next = 0;
      ref_err = 1'b0;
      exp_rv = 1'b0;
    end else begin
      cnt = ref_count();
      ref_pick(exe0_redirect_val, exe0_seq_num, exe1_redirect_val, exe1_seq_num,
               ref_oldest, cnt, pv, p1);
      if (commit_val) begin
        if (int'(commit_seq_num) != ref_oldest || cnt == 0)
          ref_err = 1'b1;
        ref_oldest = (int'(commit_seq_num) + 1) % wrap;
      end
      // rewind beats dispatch
      if (exp_rv)
        ref_next = (int'(exp_rseq) + 1) % wrap;
      else if (alloc_req && cnt != seq_window)
        ref_next = (ref_next + 1) % wrap;
      exp_rv = pv;
      if (pv) begin
        exp_rseq = p1 ? exe1_seq_num : exe0_seq_num;
        exp_rtarget = p1 ? exe1_target : exe0_target;
        exp_rcause = p1 ? exe1_cause : exe0_cause;
      end
    end
  end

  //----------------------------------------
  // helpers
  //----------------------------------------

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("Error %s expected %h got %h at %0t", name, exp, got, $time);
    errors++;
  endtask

  task automatic report_failure(input string msg);
    $display("%s at %0t", msg, $time);
    errors++;
  endtask

  task automatic end_test(input string name);
    tests_done++;
    if (errors == test_start)
      $display("test %0d %s: ok", tests_done, name);
    else
      $display("test %0d %s: FAILED with %0d errors", tests_done, name, errors - test_start);
    test_start = errors;
  endtask

  // strobes last one cycle
  task automatic next_cycle();
    @(posedge clk);
    #2;
    alloc_req = 1'b0;
    commit_val = 1'b0;
    exe0_redirect_val = 1'b0;
    exe1_redirect_val = 1'b0;
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (ref_count() > 0 && n < wait_limit) begin
      commit_val = 1'b1;
      commit_seq_num = seq_num_t'(ref_oldest);
      next_cycle();
      n++;
    end
    if (ref_count() > 0)
      report_failure("timeout while draining in-flight entries");
  endtask

  // window of count entries starting at o
  task automatic move_to(input int o, input int count);
    int n;
    drain();
    n = 0;
    while (ref_next != o && n < 2 * wrap) begin
      alloc_req = 1'b1;
      if (ref_count() > 0) begin
        commit_val = 1'b1;
        commit_seq_num = seq_num_t'(ref_oldest);
      end
      next_cycle();
      n++;
    end
    drain();
    n = 0;
    while (ref_count() < count && n < wait_limit) begin
      alloc_req = 1'b1;
      next_cycle();
      n++;
    end
    if (ref_oldest != o || ref_count() != count)
      report_failure("could not set up the in-flight window");
  endtask

  // both pipes request, then check winner and rewind
  task automatic fire_pair(input int o, input int count, input int s0, input int s1,
                           input logic exp1);
    int win;
    int n;
    move_to(o, count);
    win = exp1 ? s1 : s0;
    exe0_redirect_val = 1'b1;
    exe0_seq_num = seq_num_t'(s0);
    exe0_target = 32'h4000_0000 + s0;
    exe0_cause = cause_branch;
    exe1_redirect_val = 1'b1;
    exe1_seq_num = seq_num_t'(s1);
    exe1_target = 32'h8000_0000 + s1;
    exe1_cause = cause_exception;
    next_cycle();
    n = 0;
    while (!redirect_val && n < wait_limit) begin
      next_cycle();
      n++;
    end
    if (!redirect_val) begin
      report_failure("no redirect for a qualifying request pair");
    end else begin
      if (redirect_seq_num !== seq_num_t'(win))
        report_mismatch("redirect_seq_num", win, redirect_seq_num);
      if (redirect_target !== (exp1 ? 32'h8000_0000 + s1 : 32'h4000_0000 + s0))
        report_mismatch("redirect_target", exp1 ? 32'h8000_0000 + s1 : 32'h4000_0000 + s0,
                        redirect_target);
      if (redirect_cause !== (exp1 ? cause_exception : cause_branch))
        report_mismatch("redirect_cause", exp1 ? cause_exception : cause_branch,
                        redirect_cause);
      next_cycle();
      // next sits just past the winner
      if (alloc_seq_num !== seq_num_t'(win + 1))
        report_mismatch("alloc_seq_num", (win + 1) % wrap, alloc_seq_num);
      if (in_flight !== seq_count_t'(ref_age(win, o) + 1))
        report_mismatch("in_flight", ref_age(win, o) + 1, in_flight);
    end
  endtask

  //----------------------------------------
  // compare process
  //----------------------------------------

  always @(negedge clk) begin
    if (!reset) begin
      if (alloc_seq_num !== seq_num_t'(ref_next))
        report_mismatch("alloc_seq_num", ref_next, alloc_seq_num);
      if (oldest_seq_num !== seq_num_t'(ref_oldest))
        report_mismatch("oldest_seq_num", ref_oldest, oldest_seq_num);
      if (in_flight !== seq_count_t'(ref_count()))
        report_mismatch("in_flight", ref_count(), in_flight);
      if (alloc_full !== (ref_count() == seq_window))
        report_mismatch("alloc_full", ref_count() == seq_window, alloc_full);
      if (redirect_val !== exp_rv)
        report_mismatch("redirect_val", exp_rv, redirect_val);
      if (commit_order_error !== ref_err)
        report_mismatch("commit_order_error", ref_err, commit_order_error);
      // payload only meaningful with redirect_val
      if (exp_rv && redirect_seq_num !== exp_rseq)
        report_mismatch("redirect_seq_num", exp_rseq, redirect_seq_num);
      if (exp_rv && redirect_target !== exp_rtarget)
        report_mismatch("redirect_target", exp_rtarget, redirect_target);
      if (exp_rv && redirect_cause !== exp_rcause)
        report_mismatch("redirect_cause", exp_rcause, redirect_cause);
    end
  end

  //----------------------------------------
  // stimulus
  //----------------------------------------

  initial begin
    int i;
    int n;
    errors = 0;
    test_start = 0;
    tests_done = 0;
    rng = seed;
    reset = 1'b1;
    alloc_req = 1'b0;
    commit_val = 1'b0;
    commit_seq_num = '0;
    exe0_redirect_val = 1'b0;
    exe1_redirect_val = 1'b0;
    exe0_seq_num = '0;
    exe1_seq_num = '0;
    exe0_target = '0;
    exe1_target = '0;
    exe0_cause = cause_branch;
    exe1_cause = cause_branch;
    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;

    // allocate until full
    n = 0;
    while (!alloc_full && n < wait_limit) begin
      if (alloc_seq_num !== seq_num_t'(n))
        report_mismatch("alloc_seq_num", n, alloc_seq_num);
      alloc_req = 1'b1;
      next_cycle();
      n++;
    end
    if (!alloc_full)
      report_failure("timeout waiting for alloc_full");
    if (in_flight !== seq_count_t'(seq_window))
      report_mismatch("in_flight", seq_window, in_flight);
    alloc_req = 1'b1;
    next_cycle();
    if (alloc_seq_num !== seq_num_t'(seq_window))
      report_mismatch("alloc_seq_num", seq_window, alloc_seq_num);
    end_test("reset and allocation");

    // drain, then stream across the wrap
    drain();
    for (i = 0; i < 40; i++) begin
      if (alloc_seq_num !== seq_num_t'(seq_window + i))
        report_mismatch("alloc_seq_num", (seq_window + i) % wrap, alloc_seq_num);
      alloc_req = 1'b1;
      if (ref_count() > 0) begin
        commit_val = 1'b1;
        commit_seq_num = seq_num_t'(ref_oldest);
      end
      next_cycle();
    end
    end_test("commit and wrap");

    // oldest below, inside and above the pair
    fire_pair(2, seq_window, 10, 5, 1'b1);
    fire_pair(26, seq_window, 3, 28, 1'b1);
    fire_pair(26, seq_window, 28, 3, 1'b0);
    fire_pair(20, seq_window, 1, 2, 1'b0);
    fire_pair(5, seq_window, 9, 9, 1'b0);
    end_test("age order");

    // outside the window
    move_to(4, 5);
    exe0_redirect_val = 1'b1;
    exe0_seq_num = seq_num_t'(12);
    next_cycle();
    if (redirect_val !== 1'b0)
      report_failure("stale request produced a redirect");
    // younger request after a rewind
    move_to(4, 10);
    exe0_redirect_val = 1'b1;
    exe0_seq_num = seq_num_t'(6);
    next_cycle();
    if (redirect_val !== 1'b1)
      report_failure("live request produced no redirect");
    next_cycle();
    exe1_redirect_val = 1'b1;
    exe1_seq_num = seq_num_t'(10);
    next_cycle();
    if (redirect_val !== 1'b0)
      report_failure("squashed request produced a redirect");
    end_test("stale filter");

    fire_pair(9, 12, 15, 13, 1'b1);
    end_test("rewind after redirect");

    // random traffic against the model
    for (i = 0; i < 300; i++) begin
      rng = xorshift(rng);
      alloc_req = rng[0] | rng[1];
      if (ref_count() > 0 && rng[2] && !exp_rv) begin
        commit_val = 1'b1;
        commit_seq_num = seq_num_t'(ref_oldest);
      end
      exe0_redirect_val = (rng[5:3] == 3'd0);
      exe0_seq_num = seq_num_t'(ref_oldest) + rng[12:8];
      exe0_target = rng;
      exe0_cause = redirect_cause_t'(rng[14:13] % 3);
      exe1_redirect_val = (rng[7:6] == 2'd0);
      exe1_seq_num = seq_num_t'(ref_oldest) + rng[20:16];
      exe1_target = ~rng;
      exe1_cause = redirect_cause_t'(rng[22:21] % 3);
      next_cycle();
    end
    n = 0;
    while (exp_rv && n < wait_limit) begin
      next_cycle();
      n++;
    end
    if (exp_rv)
      report_failure("timeout waiting for redirects to settle");
    if (commit_order_error !== 1'b0)
      report_failure("commit_order_error set during legal traffic");
    alloc_req = 1'b1;
    next_cycle();
    alloc_req = 1'b1;
    next_cycle();
    // skip the oldest entry
    commit_val = 1'b1;
    commit_seq_num = seq_num_t'(ref_oldest + 1);
    next_cycle();
    if (commit_order_error !== 1'b1)
      report_mismatch("commit_order_error", 1, commit_order_error);
    end_test("random mix");

    // bound checker failures count too
    if (dut0.chk0.assert_fails != 0)
      report_failure("bound assertions reported failures");

    $display("%0d tests, %0d errors", tests_done, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
